// ==== source/eth_pkg.sv ====
// Ethernet framing constants and the FCS step for the GMII byte path
// frame sizes count DA through pad, FCS excluded
// crc32_d8 keeps the register msb first, so a good frame leaves C704DD7B
package eth_pkg;

  // one byte of the outgoing stream
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       first;   // first DA byte, CRC starts here
    logic       last;    // last pad byte, FCS follows
  } eth_byte_t;

  localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
  localparam logic [7:0]  SFD_BYTE       = 8'hD5;

  localparam logic [47:0] PTP_DST_MAC    = 48'h011B19000000; // PTP multicast
  localparam logic [47:0] SRC_MAC        = 48'h0080630009BA;

  localparam logic [15:0] ETHERTYPE_VLAN = 16'h8100;
  localparam logic [15:0] ETHERTYPE_PTP  = 16'h88F7;
  localparam logic [15:0] VLAN_TCI       = 16'h0002;

  localparam logic [7:0]  MIN_FRAME_BYTES = 8'd60;
  localparam logic [7:0]  IFG_BYTES       = 8'd12;

  localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
  localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

  // one byte of IEEE 802.3 CRC-32
  // bits go in lsb first, as they leave on the wire
  function automatic logic [31:0] crc32_d8(input logic [7:0]  data,
                                           input logic [31:0] crc);
    logic [31:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0};
      if (fb) begin
        c = c ^ 32'h04C1_1DB7;
      end
    end
    return c;
  endfunction

endpackage

// ==== source/ptp_pkg.sv ====
// PTPv2 message types, timestamp and request records
// only Sync and Follow_Up are generated, two-step mode only
package ptp_pkg;

  // 48-bit seconds, 32-bit nanoseconds, as carried in originTimestamp
  typedef struct packed {
    logic [47:0] sec;
    logic [31:0] ns;
  } ptp_ts_t;

  typedef enum logic [3:0] {
    SYNC      = 4'h0,
    FOLLOW_UP = 4'h8
  } ptp_msg_e;

  // what the scheduler hands the frame builder
  typedef struct packed {
    ptp_msg_e    msg_type;
    logic [15:0] seq_id;
    ptp_ts_t     origin_ts;   // zero for Sync
  } ptp_req_t;

  localparam logic [7:0]  PTP_VERSION   = 8'h02;   // versionPTP, minor version 0
  localparam int          PTP_MSG_LEN   = 44;      // Sync and Follow_Up body
  localparam logic [79:0] SRC_PORT_ID   = 80'h0080_63FF_FF00_09BA_0002;
  localparam logic [15:0] FLAG_TWO_STEP = 16'h0200;
  localparam logic [31:0] NS_PER_SEC    = 32'd1_000_000_000;

endpackage

// ==== source/ptp_rtc.sv ====
// free-running PTP time base, starts at zero out of reset
// NS_PER_CYCLE must be below NS_PER_SEC; no offset or rate adjust
module ptp_rtc
  import ptp_pkg::*;
#(
  parameter int NS_PER_CYCLE = 8
) (
  input  logic    tx_clk,
  input  logic    rst_sys_n,
  output ptp_ts_t time_o
);

  logic [47:0] sec_q;
  logic [31:0] ns_q;
  logic [31:0] ns_sum;

  assign ns_sum = ns_q + 32'(NS_PER_CYCLE);

  always_ff @(posedge tx_clk) begin
    if (!rst_sys_n) begin
      sec_q <= '0;
      ns_q  <= '0;
    end else if (ns_sum >= NS_PER_SEC) begin
      ns_q  <= ns_sum - NS_PER_SEC;   // carry into seconds
      sec_q <= sec_q + 48'd1;
    end else begin
      ns_q  <= ns_sum;
    end
  end

  assign time_o.sec = sec_q;
  assign time_o.ns  = ns_q;

endmodule

// ==== source/ptp_sync_sched.sv ====
// issues one Sync every SYNC_DIV ticks, then its Follow_Up
// a due Sync is dropped while a round or the builder is still busy
module ptp_sync_sched
  import ptp_pkg::*;
#(
  parameter int SYNC_DIV = 4
) (
  input  logic     tx_clk,
  input  logic     rst_sys_n,
  input  logic     sync_tick_i,
  input  logic     busy_i,
  input  logic     ts_valid_i,
  input  ptp_ts_t  egress_ts_i,
  output logic     start_o,
  output ptp_req_t req_o
);

  localparam int CW = (SYNC_DIV > 1) ? $clog2(SYNC_DIV) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_TS,     // Sync on its way, SFD not sent yet
    ST_WAIT_IDLE    // timestamp held, waiting for the gap to end
  } state_e;

  state_e      state_q;
  logic [CW-1:0] tick_cnt_q;
  logic [15:0] seq_q;
  logic        sync_due;
  logic        issue_sync;
  logic        issue_fu;

  assign sync_due   = sync_tick_i && (tick_cnt_q == CW'(SYNC_DIV - 1));
  assign issue_sync = (state_q == ST_IDLE) && sync_due && !busy_i;
  assign issue_fu   = (state_q == ST_WAIT_IDLE) && !busy_i;

  always_ff @(posedge tx_clk) begin
    if (!rst_sys_n) begin
      state_q    <= ST_IDLE;
      tick_cnt_q <= '0;
      seq_q      <= '0;
      start_o    <= 1'b0;
    end else begin
      start_o <= issue_sync || issue_fu;
      if (sync_tick_i) begin
        tick_cnt_q <= sync_due ? '0 : tick_cnt_q + CW'(1);
      end
      if (issue_sync) begin
        seq_q   <= seq_q + 16'd1;
        state_q <= ST_WAIT_TS;
      end else if (state_q == ST_WAIT_TS && ts_valid_i) begin
        state_q <= ST_WAIT_IDLE;
      end else if (issue_fu) begin
        state_q <= ST_IDLE;
      end
    end
  end

  // request fields, only sampled by the builder on start
  always_ff @(posedge tx_clk) begin
    if (issue_sync) begin
      req_o.msg_type  <= SYNC;
      req_o.seq_id    <= seq_q + 16'd1;
      req_o.origin_ts <= '0;
    end else if (state_q == ST_WAIT_TS && ts_valid_i) begin
      req_o.origin_ts <= egress_ts_i;   // egress time of this Sync
    end else if (issue_fu) begin
      req_o.msg_type <= FOLLOW_UP;      // same seq_id as the Sync
    end
  end

endmodule

// ==== source/ptp_msg_builder.sv ====
// builds one PTP frame per start, preamble through pad, one byte per cycle
// FCS is appended downstream; busy covers it and the inter-frame gap
// egress timestamp is the RTC value while the SFD is presented
module ptp_msg_builder
  import eth_pkg::*;
  import ptp_pkg::*;
#(
  parameter int VLAN_EN = 0
) (
  input  logic      tx_clk,
  input  logic      rst_sys_n,
  input  logic      start_i,
  input  ptp_req_t  req_i,
  input  ptp_ts_t   rtc_i,
  output logic      busy_o,
  output logic      ts_valid_o,
  output ptp_ts_t   egress_ts_o,
  output eth_byte_t byte_o
);

  localparam int SFD_IDX    = 7;
  localparam int HDR_BYTES  = (VLAN_EN != 0) ? 18 : 14;   // DA, SA, tag, type
  localparam int BODY_BYTES = HDR_BYTES + PTP_MSG_LEN;
  localparam int BODY_END   = SFD_IDX + 1 + BODY_BYTES;
  localparam int FRAME_LEN  = SFD_IDX + 1 +
                              ((BODY_BYTES > int'(MIN_FRAME_BYTES)) ?
                               BODY_BYTES : int'(MIN_FRAME_BYTES));
  // 4 fcs bytes plus the gap; start latency adds the last 2 idle cycles
  localparam logic [7:0] GAP_CYCLES = IFG_BYTES + 8'd4;

  logic                        active_q;
  logic [6:0]                  cnt_q;
  logic [7:0]                  gap_q;
  ptp_req_t                    req_q;
  logic                        idle_w;
  logic [HDR_BYTES*8-1:0]      hdr_w;
  logic [PTP_MSG_LEN*8-1:0]    msg_w;
  logic [BODY_BYTES*8-1:0]     body_w;
  logic [6:0]                  body_sel;

  generate
    if (VLAN_EN != 0) begin : g_vlan
      assign hdr_w = {PTP_DST_MAC, SRC_MAC, ETHERTYPE_VLAN, VLAN_TCI, ETHERTYPE_PTP};
    end else begin : g_untagged
      assign hdr_w = {PTP_DST_MAC, SRC_MAC, ETHERTYPE_PTP};
    end
  endgenerate

  // common header plus the 10-byte origin timestamp
  assign msg_w = {4'h0, req_q.msg_type,    // transportSpecific, messageType
                  PTP_VERSION,
                  16'(PTP_MSG_LEN),
                  8'h00, 8'h00,            // domain 0, reserved
                  (req_q.msg_type == SYNC) ? FLAG_TWO_STEP : 16'h0000,
                  64'h0,                   // correctionField
                  32'h0,                   // reserved
                  SRC_PORT_ID,
                  req_q.seq_id,
                  8'h00, 8'h00,            // controlField, logMessageInterval
                  req_q.origin_ts};

  assign body_w   = {hdr_w, msg_w};
  assign body_sel = 7'(BODY_END - 1) - cnt_q;   // byte 0 sits at the top
  assign idle_w   = !active_q && (gap_q == 8'd0);
  assign busy_o   = start_i || !idle_w;

  always_ff @(posedge tx_clk) begin
    if (!rst_sys_n) begin
      active_q   <= 1'b0;
      cnt_q      <= '0;
      gap_q      <= '0;
      ts_valid_o <= 1'b0;
    end else begin
      ts_valid_o <= active_q && (cnt_q == 7'(SFD_IDX));
      if (start_i && idle_w) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (active_q) begin
        if (cnt_q == 7'(FRAME_LEN - 1)) begin
          active_q <= 1'b0;
          gap_q    <= GAP_CYCLES;
        end else begin
          cnt_q <= cnt_q + 7'd1;
        end
      end else if (gap_q != 8'd0) begin
        gap_q <= gap_q - 8'd1;
      end
    end
  end

  always_ff @(posedge tx_clk) begin
    if (start_i && idle_w) begin
      req_q <= req_i;
    end
    if (active_q && cnt_q == 7'(SFD_IDX)) begin
      egress_ts_o <= rtc_i;   // time at SFD
    end
  end

  always_comb begin
    byte_o       = '0;
    byte_o.valid = active_q;
    byte_o.first = active_q && (cnt_q == 7'(SFD_IDX + 1));
    byte_o.last  = active_q && (cnt_q == 7'(FRAME_LEN - 1));
    if (!active_q) begin
      byte_o.data = 8'h00;
    end else if (cnt_q < 7'(SFD_IDX)) begin
      byte_o.data = PREAMBLE_BYTE;
    end else if (cnt_q == 7'(SFD_IDX)) begin
      byte_o.data = SFD_BYTE;
    end else if (cnt_q < 7'(BODY_END)) begin
      byte_o.data = body_w[body_sel*8 +: 8];
    end else begin
      byte_o.data = 8'h00;   // pad to minimum size
    end
  end

endmodule

// ==== source/eth_fcs_append.sv ====
// registers the byte stream onto GMII and appends the FCS
// CRC restarts at the byte marked first; the source leaves 4 idle
// cycles after last for the FCS bytes; tx_er is not driven here
module eth_fcs_append
  import eth_pkg::*;
(
  input  logic      tx_clk,
  input  logic      rst_sys_n,
  input  eth_byte_t byte_i,
  output logic [7:0] txd_o,
  output logic      tx_en_o
);

  logic [31:0] crc_q;
  logic [31:0] crc_next;
  logic [31:0] fcs_w;
  logic        in_crc_q;
  logic [2:0]  fcs_left_q;

  assign crc_next = crc32_d8(byte_i.data, byte_i.first ? CRC_INIT : crc_q);
  assign fcs_w    = ~{<<{crc_q}};   // wire order, low byte goes first

  always_ff @(posedge tx_clk) begin
    if (!rst_sys_n) begin
      txd_o      <= 8'h00;
      tx_en_o    <= 1'b0;
      in_crc_q   <= 1'b0;
      fcs_left_q <= '0;
    end else if (byte_i.valid) begin
      txd_o   <= byte_i.data;
      tx_en_o <= 1'b1;
      if (byte_i.last) begin
        in_crc_q   <= 1'b0;
        fcs_left_q <= 3'd4;
      end else if (byte_i.first) begin
        in_crc_q <= 1'b1;
      end
    end else if (fcs_left_q != 3'd0) begin
      txd_o      <= fcs_w[7:0];
      tx_en_o    <= 1'b1;
      fcs_left_q <= fcs_left_q - 3'd1;
    end else begin
      txd_o   <= 8'h00;
      tx_en_o <= 1'b0;
    end
  end

  // running CRC, shifted out a byte at a time during the FCS
  always_ff @(posedge tx_clk) begin
    if (byte_i.valid && (byte_i.first || in_crc_q)) begin
      crc_q <= crc_next;
    end else if (!byte_i.valid && fcs_left_q != 3'd0) begin
      crc_q <= {crc_q[23:0], 8'h00};   // next fcs byte moves into fcs_w[7:0]
    end
  end

endmodule

// ==== source/ptp_master_tx.sv ====
// two-step PTP master, Sync and Follow_Up over Ethernet II on GMII
// sync_tick_i pulses must be at least one frame pair apart
// tx_clk is the GMII transmit clock and the RTC clock
module ptp_master_tx
  import eth_pkg::*;
  import ptp_pkg::*;
#(
  parameter int SYNC_DIV     = 4,
  parameter int VLAN_EN      = 0,
  parameter int NS_PER_CYCLE = 8
) (
  input  logic       tx_clk,
  input  logic       rst_sys_n,
  input  logic       sync_tick_i,
  output logic [7:0] txd_o,
  output logic       tx_en_o
);

  ptp_ts_t   rtc_time;
  ptp_ts_t   egress_ts;
  ptp_req_t  req;
  logic      start;
  logic      busy;
  logic      ts_valid;
  eth_byte_t tx_byte;

  ptp_rtc #(
    .NS_PER_CYCLE (NS_PER_CYCLE)
  ) u_ptp_rtc (
    .tx_clk    (tx_clk),
    .rst_sys_n (rst_sys_n),
    .time_o    (rtc_time)
  );

  ptp_sync_sched #(
    .SYNC_DIV (SYNC_DIV)
  ) u_ptp_sync_sched (
    .tx_clk      (tx_clk),
    .rst_sys_n   (rst_sys_n),
    .sync_tick_i (sync_tick_i),
    .busy_i      (busy),
    .ts_valid_i  (ts_valid),
    .egress_ts_i (egress_ts),
    .start_o     (start),
    .req_o       (req)
  );

  ptp_msg_builder #(
    .VLAN_EN (VLAN_EN)
  ) u_ptp_msg_builder (
    .tx_clk      (tx_clk),
    .rst_sys_n   (rst_sys_n),
    .start_i     (start),
    .req_i       (req),
    .rtc_i       (rtc_time),
    .busy_o      (busy),
    .ts_valid_o  (ts_valid),
    .egress_ts_o (egress_ts),
    .byte_o      (tx_byte)
  );

  eth_fcs_append u_eth_fcs_append (
    .tx_clk    (tx_clk),
    .rst_sys_n (rst_sys_n),
    .byte_i    (tx_byte),
    .txd_o     (txd_o),
    .tx_en_o   (tx_en_o)
  );

endmodule

// ==== verif/ptp_frame_checker.sv ====
// watches GMII and checks every PTP frame against the untagged layout (VLAN_EN = 0)
// frames longer than 128 bytes are cut short in the capture buffer
// frame starts are predicted from tick_i, sampled on the rising clock edge
module ptp_frame_checker
  import eth_pkg::*;
  import ptp_pkg::*;
#(
  parameter int SYNC_DIV     = 4,
  parameter int NS_PER_CYCLE = 8
) (
  input  logic       tx_clk,
  input  logic       rst_sys_n,
  input  logic       tick_i,
  input  logic [7:0] txd_i,
  input  logic       tx_en_i,
  output int         frames_o,
  output int         idle_errs_o,
  output int         start_errs_o,
  output int         frame_errs_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_BYTES = 72;   // preamble, SFD, 60 bytes DA to pad, FCS

  logic [7:0]  frame_q [128];
  logic [63:0] sfd_cyc;
  logic [63:0] prev_sfd_cyc;
  logic [63:0] prev_ts_ns;
  logic        in_frame = 1'b0;
  logic        want_fu = 1'b0;
  int          cyc = 0;
  int          exp_start = -1;   // cycle of the next expected first byte
  int          start_cyc = 0;
  int          len = 0;
  int          ticks = 0;
  int          rounds = 0;
  int          frames = 0;
  int          idle_errs = 0;
  int          start_errs = 0;
  int          frame_errs = 0;

  assign frames_o     = frames;
  assign idle_errs_o  = idle_errs;
  assign start_errs_o = start_errs;
  assign frame_errs_o = frame_errs;

  // big endian field of n bytes from the captured frame
  function automatic logic [79:0] be_field(int off, int n);
    logic [79:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[71:0], frame_q[off + i]};
    end
    return v;
  endfunction

  task automatic expect_value(string name, logic [79:0] got, logic [79:0] exp);
    assert (got == exp) else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      frame_errs++;
    end
  endtask

  task automatic check_frame(int last_cyc);
    logic [31:0] crc;
    logic [31:0] residue;
    logic [79:0] ts;
    logic [63:0] ts_ns;
    logic [7:0]  type_byte;
    frames++;
    if (len != FRAME_BYTES) begin
      expect_value("tx_en_o cycles", 80'(len), 80'(FRAME_BYTES));
      return;
    end
    type_byte = want_fu ? {4'h0, FOLLOW_UP} : {4'h0, SYNC};
    expect_value("txd_o preamble", be_field(0, 7), 80'({7{PREAMBLE_BYTE}}));
    expect_value("txd_o SFD", be_field(7, 1), 80'(SFD_BYTE));
    expect_value("txd_o DA", be_field(8, 6), 80'(PTP_DST_MAC));
    expect_value("txd_o SA", be_field(14, 6), 80'(SRC_MAC));
    expect_value("txd_o ethertype", be_field(20, 2), 80'(ETHERTYPE_PTP));
    expect_value("txd_o messageType", be_field(22, 1), 80'(type_byte));
    expect_value("txd_o versionPTP", be_field(23, 1), 80'(PTP_VERSION));
    expect_value("txd_o messageLength", be_field(24, 2), 80'(PTP_MSG_LEN));
    expect_value("txd_o flagField", be_field(28, 2), want_fu ? 80'h0 : 80'(FLAG_TWO_STEP));
    expect_value("txd_o sourcePortIdentity", be_field(42, 10), SRC_PORT_ID);
    expect_value("txd_o sequenceId", be_field(52, 2), 80'(rounds + 1));

    // reflected CRC-32 over DA..FCS, lsb first as on the wire
    crc = CRC_INIT;
    for (int i = 8; i < FRAME_BYTES; i++) begin
      crc = crc ^ {24'h0, frame_q[i]};
      for (int b = 0; b < 8; b++) begin
        crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
    end
    for (int b = 0; b < 32; b++) begin
      residue[b] = crc[31 - b];   // msb first order
    end
    expect_value("txd_o CRC residue", 80'(residue), 80'(CRC_RESIDUE));

    ts = be_field(56, 10);
    if (!want_fu) begin
      expect_value("txd_o Sync originTimestamp", ts, 80'h0);
      sfd_cyc   = 64'(start_cyc + 7);
      exp_start <= last_cyc + int'(IFG_BYTES) + 3;   // IFG_BYTES + 2 idle cycles
      want_fu   = 1'b1;
    end else begin
      ts_ns = 64'(ts[79:32]) * 64'd1_000_000_000 + 64'(ts[31:0]);
      assert (ts[31:0] < NS_PER_SEC) else begin
        $display("** Error: txd_o Follow_Up ns = %h, limit %h", ts[31:0], NS_PER_SEC);
        frame_errs++;
      end
      if (rounds > 0) begin
        expect_value("txd_o timestamp step", 80'(ts_ns - prev_ts_ns),
                     80'(64'(NS_PER_CYCLE) * (sfd_cyc - prev_sfd_cyc)));
      end
      prev_ts_ns   = ts_ns;
      prev_sfd_cyc = sfd_cyc;
      rounds++;
      want_fu = 1'b0;
    end
  endtask

  always @(posedge tx_clk) begin
    cyc      <= cyc + 1;
    in_frame <= tx_en_i;
    if (tick_i) begin
      ticks = ticks + 1;
      if (ticks % SYNC_DIV == 0) begin
        exp_start <= cyc + 3;   // tick to first byte latency
      end
    end
    if (tx_en_i) begin
      if (len == 0) begin
        start_cyc = cyc;
      end
      if (len < 128) begin
        frame_q[len] = txd_i;
      end
      len = len + 1;
    end else if (len != 0) begin
      check_frame(cyc - 1);
      len = 0;
    end
  end

  // quiet outputs in reset and between frames
  assert property (@(posedge tx_clk)
    (cyc > 0) |-> ((tx_en_i || txd_i == 8'h00) && (rst_sys_n || !tx_en_i)))
    else begin
      $display("** Error: txd_o = %h, tx_en_o = %h outside a frame", txd_i, tx_en_i);
      idle_errs++;
    end

  assert property (@(posedge tx_clk)
    (cyc > 0) |-> ((tx_en_i && !in_frame) == (cyc == exp_start)))
    else begin
      $display("frame start timing wrong at cycle %0d, next start expected at cycle %0d",
               cyc, exp_start);
      start_errs++;
    end

endmodule

// ==== verif/tb_ptp_master_tx.sv ====
// testbench for the two-step PTP master, untagged frames, 8 ns tx_clk
// sync ticks come 200 to 400 cycles apart, so every frame pair fits between them
// all frame checks live in ptp_frame_checker
module tb_ptp_master_tx;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SYNC_DIV        = 4;
  localparam int VLAN_EN         = 0;
  localparam int NS_PER_CYCLE    = 8;
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TICKS       = 24;
  localparam int MIN_SPACING     = 200;
  localparam int MAX_SPACING     = 400;
  localparam int EXP_FRAMES      = 2 * (NUM_TICKS / SYNC_DIV);
  localparam int WATCHDOG_CYCLES = NUM_TICKS * MAX_SPACING + 2000;

  logic       tx_clk = 1'b0;
  logic       rst_sys_n;
  logic       sync_tick;
  logic [7:0] txd;
  logic       tx_en;
  int         seed;
  int         spacing;
  int         frames;
  int         idle_errs;
  int         start_errs;
  int         frame_errs;

  always #(CLK_PERIOD / 2) tx_clk = ~tx_clk;

  ptp_master_tx #(
    .SYNC_DIV     (SYNC_DIV),
    .VLAN_EN      (VLAN_EN),
    .NS_PER_CYCLE (NS_PER_CYCLE)
  ) u_ptp_master_tx (
    .tx_clk      (tx_clk),
    .rst_sys_n   (rst_sys_n),
    .sync_tick_i (sync_tick),
    .txd_o       (txd),
    .tx_en_o     (tx_en)
  );

  ptp_frame_checker #(
    .SYNC_DIV     (SYNC_DIV),
    .NS_PER_CYCLE (NS_PER_CYCLE)
  ) u_frame_checker (
    .tx_clk       (tx_clk),
    .rst_sys_n    (rst_sys_n),
    .tick_i       (sync_tick),
    .txd_i        (txd),
    .tx_en_i      (tx_en),
    .frames_o     (frames),
    .idle_errs_o  (idle_errs),
    .start_errs_o (start_errs),
    .frame_errs_o (frame_errs)
  );

  // one cycle tick, launched on the falling edge
  task automatic pulse_tick();
    @(negedge tx_clk);
    sync_tick = 1'b1;
    @(negedge tx_clk);
    sync_tick = 1'b0;
  endtask

  initial begin
    rst_sys_n = 1'b0;
    sync_tick = 1'b0;
    seed      = 83210;
    repeat (RESET_CYCLES) @(negedge tx_clk);
    rst_sys_n = 1'b1;
    for (int t = 0; t < NUM_TICKS; t++) begin
      spacing = MIN_SPACING +
                int'($unsigned($random(seed)) % (MAX_SPACING - MIN_SPACING + 1));
      repeat (spacing) @(negedge tx_clk);
      pulse_tick();
    end
    wait (frames == EXP_FRAMES);
    repeat (40) @(negedge tx_clk);   // gap drains, stray frames would show up here
    $display("frames %0d, errors idle %0d start %0d frame %0d",
             frames, idle_errs, start_errs, frame_errs);
    if (idle_errs + start_errs + frame_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles with %0d of %0d frames seen",
             WATCHDOG_CYCLES, frames, EXP_FRAMES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== ptp_master_tx.f ====
source/eth_pkg.sv
source/ptp_pkg.sv
source/ptp_rtc.sv
source/ptp_sync_sched.sv
source/ptp_msg_builder.sv
source/eth_fcs_append.sv
source/ptp_master_tx.sv
verif/ptp_frame_checker.sv
verif/tb_ptp_master_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the testbench reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ptp_master_tx -f ptp_master_tx.f || exit 1

out="$(./obj_dir/Vtb_ptp_master_tx)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
